//--- src/joiner_pkg.sv
package joiner_pkg;

  // Number of input channels feeding one lane
  localparam int CHANNELS = 4;

  // Number of lanes in a batch
  localparam int BATCH_SIZE = 2;

  // Stream data width in bits
  localparam int DATA_W = 16;

  // One keep bit per data byte
  localparam int KEEP_W = (DATA_W + 7) / 8;

  // Lane tag carried on every merged beat
  localparam int LANE_W = (BATCH_SIZE > 1) ? $clog2(BATCH_SIZE) : 1;

  // Index of the channel a lane is currently forwarding
  localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  // One beat on a channel or lane stream
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
  } in_beat_t;

  // One beat on the merged output, tagged with its source lane
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
    logic [LANE_W-1:0] lane;
  } out_beat_t;

endpackage

//--- src/channel_joiner.sv
`timescale 1ns/10ps

module channel_joiner
  import joiner_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                lane_start,
  input  logic [CHANNELS-1:0] use_channels,
  input  logic                lane_lock,
  input  logic                interrupt,
  input  in_beat_t            in_beat [CHANNELS],
  input  logic [CHANNELS-1:0] in_valid,
  output logic [CHANNELS-1:0] in_ready,
  output in_beat_t            lane_beat,
  output logic                lane_valid,
  input  logic                lane_ready,
  output logic                lane_busy,
  output logic                lane_done,
  output logic                lane_error
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } state_t;

  state_t              state;
  logic [CHANNELS-1:0] chan_mask;
  logic [CH_W-1:0]     cur_ch;
  logic [CHANNELS-1:0] mask_nxt;
  logic [CHANNELS-1:0] scan;
  logic [CH_W-1:0]     first_ch;
  logic                final_ch;
  logic                live;
  logic                pkt_end;

  // Channels still owed after the one being forwarded
  always_comb begin
    mask_nxt = chan_mask;
    mask_nxt[cur_ch] = 1'b0;
  end

  assign final_ch = (mask_nxt == '0);

  // One encoder serves both the start and the hop to the next channel
  assign scan = (state == ST_IDLE) ? use_channels : mask_nxt;

  always_comb begin
    first_ch = '0;
    for (int i = CHANNELS - 1; i >= 0; i--) begin
      if (scan[i]) begin
        first_ch = CH_W'(i);
      end
    end
  end

  // Traffic stops as soon as an interrupt is seen
  assign live = (state == ST_RUN) && !interrupt;

  // Route the current channel, keeping last only on the final one
  always_comb begin
    lane_beat = in_beat[cur_ch];
    lane_beat.last = in_beat[cur_ch].last & final_ch;
    lane_valid = live & in_valid[cur_ch];
    in_ready = '0;
    in_ready[cur_ch] = live & lane_ready;
  end

  assign pkt_end = lane_valid & lane_ready & in_beat[cur_ch].last;

  assign lane_busy = (state == ST_RUN);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      chan_mask  <= '0;
      cur_ch     <= '0;
      lane_done  <= 1'b0;
      lane_error <= 1'b0;
    end else begin
      lane_done  <= 1'b0;
      lane_error <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (lane_start) begin
            if (use_channels == '0) begin
              // Nothing to join
              lane_error <= 1'b1;
            end else begin
              state     <= ST_RUN;
              chan_mask <= use_channels;
              cur_ch    <= first_ch;
            end
          end
        end
        ST_RUN: begin
          if (interrupt) begin
            lane_error <= 1'b1;
            state      <= ST_IDLE;
          end else if (pkt_end) begin
            chan_mask <= mask_nxt;
            cur_ch    <= first_ch;
            if (final_ch) begin
              lane_done <= 1'b1;
              state     <= ST_DONE;
            end
          end
        end
        ST_DONE: begin
          // Wait here while other lanes of the batch finish
          if (!lane_lock) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/lane_merge_arb.sv
`timescale 1ns/10ps

module lane_merge_arb
  import joiner_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  in_beat_t              lane_beat [BATCH_SIZE],
  input  logic [BATCH_SIZE-1:0] lane_valid,
  output logic [BATCH_SIZE-1:0] lane_ready,
  output out_beat_t             out_beat,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic              grant_vld;
  logic [LANE_W-1:0] grant;
  logic [LANE_W-1:0] pick;
  logic              xfer;

  // Lowest lane with data pending wins
  always_comb begin
    pick = '0;
    for (int i = BATCH_SIZE - 1; i >= 0; i--) begin
      if (lane_valid[i]) begin
        pick = LANE_W'(i);
      end
    end
  end

  // Output follows the granted lane with no added delay
  always_comb begin
    out_beat.data = lane_beat[grant].data;
    out_beat.keep = lane_beat[grant].keep;
    out_beat.last = lane_beat[grant].last;
    out_beat.lane = grant;
    out_valid = grant_vld & lane_valid[grant];
    lane_ready = '0;
    lane_ready[grant] = grant_vld & out_ready;
  end

  assign xfer = out_valid & out_ready;

  // Grant stays on one lane for a whole packet
  always_ff @(posedge clk) begin
    if (rst) begin
      grant_vld <= 1'b0;
      grant     <= '0;
    end else if (!grant_vld) begin
      if (|lane_valid) begin
        grant_vld <= 1'b1;
        grant     <= pick;
      end
    end else if (xfer && out_beat.last) begin
      grant_vld <= 1'b0;
    end
  end

endmodule

//--- src/batch_sequencer.sv
`timescale 1ns/10ps

module batch_sequencer
  import joiner_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic [BATCH_SIZE-1:0] use_lanes,
  input  logic [BATCH_SIZE-1:0] lane_busy,
  input  logic [BATCH_SIZE-1:0] lane_done,
  input  logic [BATCH_SIZE-1:0] lane_error,
  output logic [BATCH_SIZE-1:0] lane_start,
  output logic [BATCH_SIZE-1:0] lane_lock,
  output logic                  operation_busy,
  output logic                  operation_complete,
  output logic                  operation_error
);

  logic                  active;
  logic [BATCH_SIZE-1:0] pending;
  logic [BATCH_SIZE-1:0] finished;
  logic [BATCH_SIZE-1:0] pending_nxt;
  logic [BATCH_SIZE-1:0] finished_nxt;
  logic                  all_done;
  logic                  lane_fail;
  logic                  cfg_error;
  logic                  accept;

  // Start only counts while no operation is running
  assign accept = start & ~active;
  assign lane_start = {BATCH_SIZE{accept}} & use_lanes;

  assign pending_nxt  = pending & ~lane_done;
  assign finished_nxt = finished | lane_done;
  assign all_done     = active & (pending_nxt == '0);
  assign lane_fail    = active & (|lane_error);

  // Finished lanes hold until the whole batch is through or aborted
  assign lane_lock = (active && !all_done && !lane_fail) ? finished_nxt : '0;

  assign operation_error = cfg_error | lane_fail;
  assign operation_busy  = active | (|lane_busy);

  always_ff @(posedge clk) begin
    if (rst) begin
      active             <= 1'b0;
      pending            <= '0;
      finished           <= '0;
      cfg_error          <= 1'b0;
      operation_complete <= 1'b0;
    end else begin
      cfg_error          <= 1'b0;
      operation_complete <= 1'b0;
      if (!active) begin
        if (start) begin
          if (use_lanes == '0) begin
            cfg_error <= 1'b1;
          end else begin
            active   <= 1'b1;
            pending  <= use_lanes;
            finished <= '0;
          end
        end
      end else if (lane_fail) begin
        // Error wins over a completion in the same cycle
        active <= 1'b0;
      end else if (all_done) begin
        active             <= 1'b0;
        operation_complete <= 1'b1;
      end else begin
        pending  <= pending_nxt;
        finished <= finished_nxt;
      end
    end
  end

endmodule

//--- src/batch_joiner_top.sv
`timescale 1ns/10ps

module batch_joiner_top
  import joiner_pkg::*;
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                start,
  input  logic [CHANNELS-1:0]                 use_channels,
  input  logic [BATCH_SIZE-1:0]               use_lanes,
  input  logic                                interrupt,
  input  in_beat_t                            in_beat [BATCH_SIZE][CHANNELS],
  input  logic [BATCH_SIZE-1:0][CHANNELS-1:0] in_valid,
  output logic [BATCH_SIZE-1:0][CHANNELS-1:0] in_ready,
  output out_beat_t                           out_beat,
  output logic                                out_valid,
  input  logic                                out_ready,
  output logic                                operation_busy,
  output logic                                operation_complete,
  output logic                                operation_error,
  output logic                                transmission
);

  in_beat_t              lane_beat [BATCH_SIZE];
  logic [BATCH_SIZE-1:0] lane_valid;
  logic [BATCH_SIZE-1:0] lane_ready;
  logic [BATCH_SIZE-1:0] lane_start;
  logic [BATCH_SIZE-1:0] lane_lock;
  logic [BATCH_SIZE-1:0] lane_busy;
  logic [BATCH_SIZE-1:0] lane_done;
  logic [BATCH_SIZE-1:0] lane_error;
  logic                  arb_rst;

  for (genvar l = 0; l < BATCH_SIZE; l++) begin : g_lane
    channel_joiner u_lane (
      .clk          (clk),
      .rst          (rst),
      .lane_start   (lane_start[l]),
      .use_channels (use_channels),
      .lane_lock    (lane_lock[l]),
      .interrupt    (interrupt),
      .in_beat      (in_beat[l]),
      .in_valid     (in_valid[l]),
      .in_ready     (in_ready[l]),
      .lane_beat    (lane_beat[l]),
      .lane_valid   (lane_valid[l]),
      .lane_ready   (lane_ready[l]),
      .lane_busy    (lane_busy[l]),
      .lane_done    (lane_done[l]),
      .lane_error   (lane_error[l])
    );
  end

  // An aborted operation leaves a truncated packet, so drop its grant
  assign arb_rst = rst | operation_error;

  lane_merge_arb u_arb (
    .clk        (clk),
    .rst        (arb_rst),
    .lane_beat  (lane_beat),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  batch_sequencer u_seq (
    .clk                (clk),
    .rst                (rst),
    .start              (start),
    .use_lanes          (use_lanes),
    .lane_busy          (lane_busy),
    .lane_done          (lane_done),
    .lane_error         (lane_error),
    .lane_start         (lane_start),
    .lane_lock          (lane_lock),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error)
  );

  assign transmission = out_valid & out_ready;

endmodule

//--- verif/batch_joiner_asserts.sv
`timescale 1ns/10ps

module batch_joiner_asserts
  import joiner_pkg::*;
(
  input logic                                clk,
  input logic                                rst,
  input logic                                interrupt,
  input logic [BATCH_SIZE-1:0][CHANNELS-1:0] in_ready,
  input out_beat_t                           out_beat,
  input logic                                out_valid,
  input logic                                out_ready,
  input logic                                operation_busy,
  input logic                                operation_complete,
  input logic                                operation_error,
  input logic                                transmission
);

  // Stalled beat must not move
  assert property (@(posedge clk) disable iff (rst || interrupt)
    out_valid && !out_ready |=> $stable(out_beat))
    else $error("out_beat changed while stalled");

  assert property (@(posedge clk) disable iff (rst || interrupt)
    out_valid && !out_ready |=> out_valid)
    else $error("out_valid dropped while stalled");

  assert property (@(posedge clk) disable iff (rst)
    !(operation_complete && operation_error))
    else $error("operation_complete and operation_error high together");

  // Completion is a single pulse
  assert property (@(posedge clk) disable iff (rst)
    operation_complete |=> !operation_complete)
    else $error("operation_complete held longer than one cycle");

  // Quiet outputs once reset has taken hold
  assert property (@(posedge clk)
    rst && $past(rst) |-> !out_valid && (in_ready == '0) && !operation_busy
      && !operation_complete && !operation_error && !transmission)
    else $error("output active during reset");

endmodule

bind batch_joiner_top batch_joiner_asserts u_asserts (
  .clk                (clk),
  .rst                (rst),
  .interrupt          (interrupt),
  .in_ready           (in_ready),
  .out_beat           (out_beat),
  .out_valid          (out_valid),
  .out_ready          (out_ready),
  .operation_busy     (operation_busy),
  .operation_complete (operation_complete),
  .operation_error    (operation_error),
  .transmission       (transmission)
);

//--- verif/tb_batch_joiner.sv
`timescale 1ns/10ps

module tb_batch_joiner
  import joiner_pkg::*;
();

  localparam int RESET_CYC = 10;
  localparam int N_OPS = 11;
  localparam int MAX_BEATS = BATCH_SIZE * CHANNELS * 4;
  localparam int OP_LIMIT = MAX_BEATS * 4;
  localparam int WATCHDOG_CYC = N_OPS * MAX_BEATS * 4 + 2 * RESET_CYC;

  logic                                clk = 1'b0;
  logic                                rst;
  logic                                start;
  logic [CHANNELS-1:0]                 use_channels;
  logic [BATCH_SIZE-1:0]               use_lanes;
  logic                                interrupt;
  in_beat_t                            in_beat [BATCH_SIZE][CHANNELS] = '{default: '0};
  logic [BATCH_SIZE-1:0][CHANNELS-1:0] in_valid = '0;
  logic [BATCH_SIZE-1:0][CHANNELS-1:0] in_ready;
  out_beat_t                           out_beat;
  logic                                out_valid;
  logic                                out_ready = 1'b0;
  logic                                operation_busy;
  logic                                operation_complete;
  logic                                operation_error;
  logic                                transmission;

  // Channel packet store and reference packets per lane
  in_beat_t chan_data [BATCH_SIZE][CHANNELS][4];
  int       chan_len [BATCH_SIZE][CHANNELS] = '{default: 0};
  int       chan_idx [BATCH_SIZE][CHANNELS] = '{default: 0};
  in_beat_t exp_q [BATCH_SIZE][$];
  logic     load;

  integer seed = 72;
  int     ready_mode = 0;
  int     checks = 0;
  int     errors = 0;
  int     complete_cnt = 0;
  int     error_cnt = 0;
  int     first_lane = 0;
  logic   first_pending = 1'b0;
  logic   in_pkt = 1'b0;
  int     pkt_lane = 0;
  logic   op_running = 1'b0;

  batch_joiner_top dut0 (
    .clk                (clk),
    .rst                (rst),
    .start              (start),
    .use_channels       (use_channels),
    .use_lanes          (use_lanes),
    .interrupt          (interrupt),
    .in_beat            (in_beat),
    .in_valid           (in_valid),
    .in_ready           (in_ready),
    .out_beat           (out_beat),
    .out_valid          (out_valid),
    .out_ready          (out_ready),
    .operation_busy     (operation_busy),
    .operation_complete (operation_complete),
    .operation_error    (operation_error),
    .transmission       (transmission)
  );

  always #20 clk = ~clk;

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("** Error: %s got %h expected %h", name, got, want);
    end
  endtask

  // Each channel source walks its own stored packet
  always @(posedge clk) begin
    int nxt;
    for (int l = 0; l < BATCH_SIZE; l++) begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (load) begin
          nxt = 0;
        end else if (in_valid[l][c] && in_ready[l][c]) begin
          nxt = chan_idx[l][c] + 1;
        end else begin
          nxt = chan_idx[l][c];
        end
        chan_idx[l][c] = nxt;
        if (nxt < chan_len[l][c]) begin
          in_valid[l][c] <= 1'b1;
          in_beat[l][c]  <= chan_data[l][c][nxt];
        end else begin
          in_valid[l][c] <= 1'b0;
          in_beat[l][c]  <= '0;
        end
      end
    end
  end

  // Sink readiness is steady, random or held off
  always @(posedge clk) begin
    case (ready_mode)
      1: out_ready <= 1'($random(seed));
      2: out_ready <= 1'b0;
      default: out_ready <= 1'b1;
    endcase
  end

  // Output monitor against the reference packets
  always @(posedge clk) begin
    in_beat_t exp;
    int       l;
    if (!rst) begin
      compare_field("transmission", 32'(transmission), 32'(out_valid & out_ready));
      if (out_valid && out_ready) begin
        l = int'(out_beat.lane);
        if (in_pkt) begin
          compare_field("out_beat.lane", 32'(l), 32'(pkt_lane));
        end else if (first_pending) begin
          compare_field("out_beat.lane", 32'(l), 32'(first_lane));
          first_pending = 1'b0;
        end
        checks++;
        assert (exp_q[l].size() > 0) else begin
          errors++;
          $display("Beat on lane %0d arrived with nothing left in its packet", l);
        end
        if (exp_q[l].size() > 0) begin
          exp = exp_q[l].pop_front();
          compare_field("out_beat.data", 32'(out_beat.data), 32'(exp.data));
          compare_field("out_beat.keep", 32'(out_beat.keep), 32'(exp.keep));
          compare_field("out_beat.last", 32'(out_beat.last), 32'(exp.last));
        end
        in_pkt = !out_beat.last;
        pkt_lane = l;
      end
      // Aborted packets are cut short
      if (operation_error) begin
        in_pkt = 1'b0;
      end
      if (op_running) begin
        if (operation_complete || operation_error) begin
          op_running = 1'b0;
        end else begin
          compare_field("operation_busy", 32'(operation_busy), 32'd1);
        end
      end
      if (start && use_lanes != '0) begin
        op_running = 1'b1;
      end
      if (operation_complete) begin
        complete_cnt++;
        for (int k = 0; k < BATCH_SIZE; k++) begin
          compare_field("beats outstanding at operation_complete",
                        32'(exp_q[k].size()), 32'd0);
        end
      end
      if (operation_error) begin
        error_cnt++;
      end
    end
  end

  // One operation; abort_after > 0 raises interrupt that many cycles after start
  task automatic run_op(input logic [BATCH_SIZE-1:0] lanes, input logic [CHANNELS-1:0] chans,
                        input int ready_sel, input int abort_after);
    int       len;
    int       final_c;
    int       c0;
    int       e0;
    int       n;
    logic     expect_err;
    in_beat_t b;
    @(negedge clk);
    ready_mode = ready_sel;
    final_c = 0;
    for (int c = 0; c < CHANNELS; c++) begin
      if (chans[c]) final_c = c;
    end
    for (int l = BATCH_SIZE - 1; l >= 0; l--) begin
      if (lanes[l]) first_lane = l;
    end
    for (int l = 0; l < BATCH_SIZE; l++) begin
      exp_q[l].delete();
      for (int c = 0; c < CHANNELS; c++) begin
        len = (lanes[l] && chans[c]) ? 1 + int'($unsigned($random(seed)) % 4) : 0;
        chan_len[l][c] = len;
        for (int i = 0; i < len; i++) begin
          b.data = DATA_W'($random(seed));
          b.keep = KEEP_W'($random(seed));
          b.last = (i == len - 1);
          chan_data[l][c][i] = b;
          b.last = (c == final_c) && (i == len - 1);
          exp_q[l].push_back(b);
        end
      end
    end
    first_pending = (lanes != '0) && (chans != '0);
    c0 = complete_cnt;
    e0 = error_cnt;
    @(posedge clk);
    load <= 1'b1;
    @(posedge clk);
    load         <= 1'b0;
    start        <= 1'b1;
    use_lanes    <= lanes;
    use_channels <= chans;
    @(posedge clk);
    start <= 1'b0;
    if (abort_after > 0) begin
      repeat (abort_after) @(posedge clk);
      interrupt <= 1'b1;
      @(posedge clk);
      interrupt <= 1'b0;
    end
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (complete_cnt == c0 && error_cnt == e0 && n < OP_LIMIT);
    // Room for a stray second pulse to show up
    repeat (3) @(negedge clk);
    checks++;
    assert (n < OP_LIMIT) else begin
      errors++;
      $display("Operation never ended with a complete or error pulse");
    end
    expect_err = (lanes == '0) || (abort_after > 0);
    compare_field("operation_complete pulses", 32'(complete_cnt - c0), expect_err ? 0 : 1);
    compare_field("operation_error pulses", 32'(error_cnt - e0), expect_err ? 1 : 0);
    for (int l = 0; l < BATCH_SIZE; l++) begin
      exp_q[l].delete();
    end
    first_pending = 1'b0;
  endtask

  initial begin
    logic [CHANNELS-1:0] chans;
    rst          = 1'b1;
    start        = 1'b0;
    use_lanes    = '0;
    use_channels = '0;
    interrupt    = 1'b0;
    load         = 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    rst <= 1'b0;
    run_op(2'b01, 4'b1011, 0, 0);
    run_op(2'b10, 4'b0110, 0, 0);
    run_op(2'b11, 4'b1111, 0, 0);
    run_op(2'b11, 4'b0101, 1, 0);
    run_op(2'b00, 4'b0011, 0, 0);
    for (int k = 0; k < 4; k++) begin
      chans = CHANNELS'($random(seed));
      if (chans == '0) chans = 4'b0001;
      run_op(2'b11, chans, 1, 0);
    end
    // Sink held off so the lanes are still running when interrupt hits
    run_op(2'b11, 4'b1111, 2, 3);
    run_op(2'b11, 4'b1101, 1, 0);
    @(negedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- vlog.f
src/joiner_pkg.sv
src/channel_joiner.sv
src/lane_merge_arb.sv
src/batch_sequencer.sv
src/batch_joiner_top.sv
verif/batch_joiner_asserts.sv
verif/tb_batch_joiner.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_batch_joiner
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log

SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	set -o pipefail; ./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
